//--- Makefile
VERILATOR ?= verilator
TOP       ?= rvCoreTb
FILELIST  ?= sources.f
OBJDIR    ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS      ?= *** PASSED ***

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "variables:  VERILATOR TOP FILELIST OBJDIR VFLAGS PASS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF '$(PASS)'

clean:
	rm -rf $(OBJDIR)

//--- hdl/rvAlu.sv
module rvAlu import rvPkg::*; (
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1Data,
    input  logic [xlen-1:0] rs2Data,
    input  logic [xlen-1:0] imm,
    input  logic            aluSrcA,       // pc for auipc
    input  logic            aluSrcB,       // imm for i, load, store, jalr
    input  aluOpT           aluOp,
    output logic [xlen-1:0] aluResult,
    output logic            zeroFlag,
    output logic            signedLess,
    output logic            unsignedLess
);

    logic [xlen-1:0] srcA;
    logic [xlen-1:0] srcB;
    logic [4:0]      shamt;
    logic [xlen:0]   diff;                 // extra bit is the borrow

    assign srcA  = aluSrcA ? pc : rs1Data;
    assign srcB  = aluSrcB ? imm : rs2Data;
    assign shamt = srcB[4:0];

    // flags compare the two operands
    assign diff         = {1'b0, srcA} - {1'b0, srcB};
    assign zeroFlag     = (diff[xlen-1:0] == '0);
    assign unsignedLess = diff[xlen];      // borrow out
    assign signedLess   = (srcA[xlen-1] != srcB[xlen-1]) ? srcA[xlen-1]  // signs differ
                                                         : diff[xlen-1];

    always_comb begin
        case (aluOp)
            aluAdd:  aluResult = srcA + srcB;
            aluSub:  aluResult = diff[xlen-1:0];
            aluSll:  aluResult = srcA << shamt;
            aluSlt:  aluResult = {{(xlen-1){1'b0}}, signedLess};
            aluSltu: aluResult = {{(xlen-1){1'b0}}, unsignedLess};
            aluXor:  aluResult = srcA ^ srcB;
            aluSrl:  aluResult = srcA >> shamt;
            aluSra:  aluResult = $signed(srcA) >>> shamt;  // sign fill
            aluOr:   aluResult = srcA | srcB;
            aluAnd:  aluResult = srcA & srcB;
            default: aluResult = '0;
        endcase
    end

endmodule

//--- hdl/rvControlUnit.sv
module rvControlUnit import rvPkg::*; (
    input  logic            run,           // gates all state writes
    input  logic [xlen-1:0] instr,
    input  logic            zeroFlag,
    input  logic            signedLess,
    input  logic            unsignedLess,
    output pcSrcT           pcSrc,
    output resultSrcT       resultSrc,
    output logic            memWrite,
    output logic            aluSrcA,       // 1 selects pc
    output logic            aluSrcB,       // 1 selects imm
    output immSrcT          immSrc,
    output logic            regWrite,
    output aluOpT           aluOp
);

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       funct7b5;                  // sub / sra select
    logic       regWriteRaw;
    logic       isBranch;
    logic       jump;
    logic       taken;

    assign opcode   = opcodeT'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];

    function automatic aluOpT functToOp(input logic [2:0] f3, input logic alt);
        aluOpT op;
        case (f3)
            3'b000:  op = alt ? aluSub : aluAdd;
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b011:  op = aluSltu;
            3'b100:  op = aluXor;
            3'b101:  op = alt ? aluSra : aluSrl;
            3'b110:  op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    always_comb begin
        case (opcode)                      // alu operation
            opR:      aluOp = functToOp(funct3, funct7b5);
            opImm:    aluOp = functToOp(funct3, funct7b5 && (funct3 == 3'b101)); // srai only
            opBranch: aluOp = aluSub;
            default:  aluOp = aluAdd;      // address and auipc sums
        endcase

        case (opcode)                      // writeback source
            opLoad:        resultSrc = resMem;
            opJal, opJalr: resultSrc = resPcPlus4;
            opLui:         resultSrc = resImm;
            default:       resultSrc = resAlu;
        endcase

        case (opcode)                      // operand b
            opImm, opLoad, opStore, opJalr, opAuipc: aluSrcB = 1'b1;
            default:                                aluSrcB = 1'b0;
        endcase

        case (opcode)                      // immediate format
            opStore:        immSrc = immS;
            opBranch:       immSrc = immB;
            opLui, opAuipc: immSrc = immU;
            opJal:          immSrc = immJ;
            default:        immSrc = immI;
        endcase

        case (opcode)                      // register write
            opR, opImm, opLoad, opJal, opJalr, opLui, opAuipc: regWriteRaw = 1'b1;
            default:                                          regWriteRaw = 1'b0;
        endcase

        case (funct3)                      // branch condition from flags
            3'b000:  taken = zeroFlag;      // beq
            3'b001:  taken = !zeroFlag;     // bne
            3'b100:  taken = signedLess;    // blt
            3'b101:  taken = !signedLess;   // bge
            3'b110:  taken = unsignedLess;  // bltu
            3'b111:  taken = !unsignedLess; // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign aluSrcA  = (opcode == opAuipc);
    assign isBranch = (opcode == opBranch);
    assign jump     = (opcode == opJal) || (opcode == opJalr);
    assign regWrite = regWriteRaw && run;  // unknown opcodes never write
    assign memWrite = (opcode == opStore) && run;

    always_comb begin
        case ({jump, isBranch && taken})   // flag driven next pc
            2'b10:   pcSrc = aluSrcB ? pcJalr : pcTarget;  // only jalr jumps with an imm operand
            2'b01:   pcSrc = pcTarget;
            default: pcSrc = pcPlus4;
        endcase
    end

    always_comb begin
        jalrOnly: assert final ((pcSrc != pcJalr) || (opcode == opJalr))
            else $error("pcJalr selected for opcode %b", instr[6:0]);
    end

endmodule

//--- hdl/rvCore.sv
module rvCore import rvPkg::*; #(
    parameter int imemDepth = 256,
    parameter int dmemDepth = 256
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         run,        // core steps while high
    input  logic                         imemWe,
    input  logic [$clog2(imemDepth)-1:0] imemAddr,
    input  logic [xlen-1:0]              imemData,
    input  logic [4:0]                   dbgRegAddr,
    output logic [xlen-1:0]              dbgRegData,
    output logic [xlen-1:0]              pc
);

    logic [xlen-1:0] instr;
    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] result;              // writeback value
    logic            zeroFlag;
    logic            signedLess;
    logic            unsignedLess;
    logic            memWrite;
    logic            regWrite;
    logic            aluSrcA;
    logic            aluSrcB;
    pcSrcT           pcSrc;
    resultSrcT       resultSrc;
    immSrcT          immSrc;
    aluOpT           aluOp;

    rvFetch #(.imemDepth(imemDepth)) fetch (
        .clk, .rstN, .run, .imemWe, .imemAddr, .imemData,
        .pcSrc, .imm, .aluResult, .instr, .pc, .pcPlus4
    );

    rvControlUnit control (
        .run, .instr, .zeroFlag, .signedLess, .unsignedLess,
        .pcSrc, .resultSrc, .memWrite, .aluSrcA, .aluSrcB, .immSrc, .regWrite, .aluOp
    );

    rvImmGen immGen (.instr, .immSrc, .imm);

    rvRegFile regFile (
        .clk, .rstN, .writeEn(regWrite),
        .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]),
        .writeData(result), .dbgRegAddr, .rs1Data, .rs2Data, .dbgRegData
    );

    rvAlu alu (
        .pc, .rs1Data, .rs2Data, .imm, .aluSrcA, .aluSrcB, .aluOp,
        .aluResult, .zeroFlag, .signedLess, .unsignedLess
    );

    rvMemStage #(.dmemDepth(dmemDepth)) memStage (
        .clk, .memWrite, .aluResult, .rs2Data, .imm, .pcPlus4, .resultSrc, .result
    );

endmodule

//--- hdl/rvFetch.sv
module rvFetch import rvPkg::*; #(
    parameter int imemDepth = 256           // instruction words
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic                         run,
    input  logic                         imemWe,    // program load strobe
    input  logic [$clog2(imemDepth)-1:0] imemAddr,  // word index
    input  logic [xlen-1:0]              imemData,
    input  pcSrcT                        pcSrc,
    input  logic [xlen-1:0]              imm,
    input  logic [xlen-1:0]              aluResult, // jalr target sum
    output logic [xlen-1:0]              instr,
    output logic [xlen-1:0]              pc,
    output logic [xlen-1:0]              pcPlus4
);

    localparam int addrW = $clog2(imemDepth);

    logic [xlen-1:0] imem [imemDepth];     // program words from the load port
    logic [xlen-1:0] nextPc;

    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    assign instr   = imem[pc[addrW+1:2]];  // word index of pc
    assign pcPlus4 = pc + 32'd4;

    always_comb begin
        case (pcSrc)
            pcTarget: nextPc = pc + imm;                   // branch taken, jal
            pcJalr:   nextPc = {aluResult[xlen-1:1], 1'b0};
            default:  nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= '0;
        end else if (run) begin
            pc <= nextPc;                  // one instruction per cycle
        end
    end

    // targets come from immgen or the alu, so a bad offset shows up here
    nextPcAligned: assert property (@(posedge clk) disable iff (!rstN)
        run |-> (nextPc[1:0] == 2'b00))
        else $error("misaligned next pc %h", nextPc);

    noLoadWhileRun: assert property (@(posedge clk) disable iff (!rstN)
        !(imemWe && run))
        else $error("imem write while core running");

endmodule

//--- hdl/rvImmGen.sv
module rvImmGen import rvPkg::*; (
    input  logic [xlen-1:0] instr,
    input  immSrcT          immSrc,
    output logic [xlen-1:0] imm            // sign extended
);

    logic signBit;

    assign signBit = instr[31];            // every format signs from bit 31

    always_comb begin
        case (immSrc)
            immI: imm = {{20{signBit}}, instr[31:20]};
            immS: imm = {{20{signBit}}, instr[31:25], instr[11:7]};
            immB: imm = {{19{signBit}},
                         instr[31],
                         instr[7],
                         instr[30:25],
                         instr[11:8],
                         1'b0};            // halfword offset
            immU: imm = {instr[31:12], 12'b0};  // upper 20, low zero filled
            immJ: imm = {{11{signBit}},
                         instr[31],
                         instr[19:12],
                         instr[20],
                         instr[30:21],
                         1'b0};
            default: imm = '0;
        endcase
    end

endmodule

//--- hdl/rvMemStage.sv
module rvMemStage import rvPkg::*; #(
    parameter int dmemDepth = 256           // data words
) (
    input  logic            clk,
    input  logic            memWrite,      // gated by run upstream
    input  logic [xlen-1:0] aluResult,     // byte address
    input  logic [xlen-1:0] rs2Data,       // store data
    input  logic [xlen-1:0] imm,           // lui value
    input  logic [xlen-1:0] pcPlus4,       // link value
    input  resultSrcT       resultSrc,
    output logic [xlen-1:0] result
);

    localparam int addrW = $clog2(dmemDepth);

    logic [xlen-1:0]  dmem [dmemDepth];
    logic [addrW-1:0] wordAddr;
    logic [xlen-1:0]  readData;

    assign wordAddr = aluResult[addrW+1:2]; // low two bits dropped

    always_ff @(posedge clk) begin
        if (memWrite) begin
            dmem[wordAddr] <= rs2Data;     // sw
        end
    end

    assign readData = dmem[wordAddr];      // combinational lw

    always_comb begin
        case (resultSrc)
            resMem:     result = readData;
            resPcPlus4: result = pcPlus4;  // jal, jalr
            resImm:     result = imm;
            default:    result = aluResult;
        endcase
    end

    // address comes from rs1 plus the s-format offset
    storeAligned: assert property (@(posedge clk)
        memWrite |-> (aluResult[1:0] == 2'b00))
        else $error("misaligned store to %h", aluResult);

endmodule

//--- hdl/rvPkg.sv
package rvPkg;

    localparam int xlen = 32;             // data and address width

    // major opcodes of the supported subset
    typedef enum logic [6:0] {
        opR      = 7'b0110011,            // register-register alu
        opImm    = 7'b0010011,            // register-immediate alu
        opLoad   = 7'b0000011,            // lw only
        opStore  = 7'b0100011,            // sw only
        opBranch = 7'b1100011,            // beq..bgeu
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111,
        opAuipc  = 7'b0010111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,                           // also used for branch compare
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluOpT;

    typedef enum logic [2:0] {
        immI = 3'd0,                      // alu imm, loads, jalr
        immS = 3'd1,                      // stores
        immB = 3'd2,                      // branches
        immU = 3'd3,                      // lui, auipc
        immJ = 3'd4                       // jal
    } immSrcT;

    typedef enum logic [1:0] {
        resAlu,
        resMem,
        resPcPlus4,                       // link value
        resImm                            // lui
    } resultSrcT;

    typedef enum logic [1:0] {
        pcPlus4,                          // sequential
        pcTarget,                         // pc + imm
        pcJalr                            // alu sum, bit 0 cleared
    } pcSrcT;

endpackage

//--- hdl/rvRegFile.sv
module rvRegFile import rvPkg::*; (
    input  logic            clk,
    input  logic            rstN,
    input  logic            writeEn,       // already gated by run
    input  logic [4:0]      rs1,
    input  logic [4:0]      rs2,
    input  logic [4:0]      rd,
    input  logic [xlen-1:0] writeData,
    input  logic [4:0]      dbgRegAddr,
    output logic [xlen-1:0] rs1Data,
    output logic [xlen-1:0] rs2Data,
    output logic [xlen-1:0] dbgRegData
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (rd != 5'd0)) begin
            regs[rd] <= writeData;         // x0 writes dropped here
        end
    end

    // x0 is cleared by reset and never written afterwards
    assign rs1Data    = regs[rs1];
    assign rs2Data    = regs[rs2];
    assign dbgRegData = regs[dbgRegAddr];  // testbench view

    x0ReadsZero: assert property (@(posedge clk) disable iff (!rstN)
        ((rs1 == 5'd0) |-> (rs1Data == '0)) and ((rs2 == 5'd0) |-> (rs2Data == '0)))
        else $error("x0 read nonzero");

endmodule

//--- sources.f
hdl/rvPkg.sv
hdl/rvFetch.sv
hdl/rvControlUnit.sv
hdl/rvImmGen.sv
hdl/rvRegFile.sv
hdl/rvAlu.sv
hdl/rvMemStage.sv
hdl/rvCore.sv
verif/rvCoreTb.sv

//--- verif/rvCoreTb.sv
module rvCoreTb import rvPkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int imemDepth = 256;
    localparam int dmemDepth = 256;
    localparam int addrW     = $clog2(imemDepth);
    localparam int runLimit  = 2000;       // cycles before a run counts as hung

    logic             clk = 1'b0;
    logic             rstN;
    logic             run;
    logic             imemWe;
    logic [addrW-1:0] imemAddr;
    logic [31:0]      imemData;
    logic [4:0]       dbgRegAddr;
    logic [31:0]      dbgRegData;
    logic [31:0]      pc;

    logic [31:0] prog [$];                 // program being assembled
    logic [31:0] expReg [32];              // expected register image
    logic [31:0] lfsrState = 32'hafce_5da9;

    rvCore #(.imemDepth(imemDepth), .dmemDepth(dmemDepth)) UUT (
        .clk, .rstN, .run, .imemWe, .imemAddr, .imemData, .dbgRegAddr, .dbgRegData, .pc
    );

    always #4 clk = ~clk;                  // 8 ns period

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] lfsrBits(input int n);
        logic [31:0] w;
        logic        fb;
        w = '0;
        for (int i = 0; i < n; i++) begin
            fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], fb};
            w         = {w[30:0], fb};
        end
        return w;
    endfunction

    function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // sw
    endfunction

    function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] encU(input logic [19:0] u, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {u, rd, op};
    endfunction

    function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // rv32i result rules with b as rs2 or the sign extended immediate
    function automatic logic [31:0] aluRef(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return {31'd0, $signed(a) < $signed(b)};
            3'd3:    return {31'd0, a < b};
            3'd4:    return a ^ b;
            3'd5:    return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchRef(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    function automatic void emitConst(input logic [4:0] rd, input logic [31:0] v);
        logic [31:0] hi;
        hi = v + 32'h800;                  // addi adds the low part sign extended
        prog.push_back(encU(hi[31:12], rd, opLui));
        prog.push_back(encI(v[11:0], rd, 3'd0, rd, opImm));
        expReg[rd] = v;
    endfunction

    function automatic logic [31:0] endProgram();
        logic [31:0] endAddr;
        endAddr = 32'(prog.size() * 4);
        prog.push_back(encJ(21'd0, 5'd0)); // jal x0, 0 spins here
        return endAddr;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic checkRegs();
        for (int i = 0; i < 32; i++) begin
            dbgRegAddr = 5'(i);
            #1;                            // debug port is combinational
            checkValue($sformatf("x%0d", i), dbgRegData, expReg[5'(i)]);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic newProgram();
        prog.delete();
        expReg = '{default: '0};
        run    = 1'b0;
        imemWe = 1'b0;
        rstN   = 1'b0;
        repeat (16) @(posedge clk);
        #1 rstN = 1'b1;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < prog.size(); i++) begin
            imemWe   = 1'b1;
            imemAddr = addrW'(i);
            imemData = prog[i];
            @(posedge clk);
            #1;
        end
        imemWe = 1'b0;
    endtask

    task automatic runUntil(input logic [31:0] endAddr);
        int cycles;
        cycles = 0;
        run    = 1'b1;
        do begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > runLimit) begin
                $display("timeout: pc stuck at %h and never reached %h", pc, endAddr);
                $display("*** FAILED ***");
                $fatal(1, "run timeout");
            end
        end while (pc != endAddr);
        run = 1'b0;
    endtask

    task automatic testReset();
        newProgram();
        checkValue("pc", pc, 32'd0);
        checkRegs();
        prog.push_back(encI(12'd123, 5'd0, 3'd0, 5'd0, opImm)); // addi x0 must be lost
        prog.push_back(encI(12'd7, 5'd0, 3'd0, 5'd1, opImm));
        expReg[1] = 32'd7;
        loadProgram();
        runUntil(endProgram());
        checkRegs();
    endtask

    task automatic testAlu();
        logic [31:0] a;
        logic [31:0] b;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        logic [4:0]  rd;
        for (int round = 0; round < 2; round++) begin
            newProgram();
            a     = lfsrBits(32);
            b     = lfsrBits(32);
            a[31] = (round == 0);          // neg/pos, then pos/neg
            b[31] = (round != 0);
            emitConst(5'd1, a);
            emitConst(5'd2, b);
            rd = 5'd3;
            for (int op = 0; op < 10; op++) begin   // 8 and 9 are sub, sra
                f3  = (op < 8) ? 3'(op) : ((op == 8) ? 3'd0 : 3'd5);
                alt = (op >= 8);
                prog.push_back(encR(alt ? 7'h20 : 7'h00, 5'd2, 5'd1, f3, rd));
                expReg[rd] = aluRef(f3, alt, a, b);
                rd++;
            end
            for (int op = 0; op < 9; op++) begin    // 8 is srai
                f3  = (op < 8) ? 3'(op) : 3'd5;
                alt = (op == 8);
                imm = 12'(lfsrBits(12));
                if (f3 == 3'd1 || f3 == 3'd5) imm = {1'b0, alt, 5'd0, imm[4:0]};
                prog.push_back(encI(imm, 5'd1, f3, rd, opImm));
                expReg[rd] = aluRef(f3, alt, a, {{20{imm[11]}}, imm});
                rd++;
            end
            loadProgram();
            runUntil(endProgram());
            checkRegs();
        end
    endtask

    task automatic testMemory();
        logic [31:0] data [4];
        logic [11:0] offs [4];
        newProgram();
        offs = '{12'h000, 12'h004, 12'h01c, 12'hffc};   // last one is -4
        prog.push_back(encI(12'h100, 5'd0, 3'd0, 5'd1, opImm));
        expReg[1] = 32'h100;
        for (int k = 0; k < 4; k++) begin
            data[k] = lfsrBits(32);
            emitConst(5'(2 + k), data[k]);
        end
        for (int k = 0; k < 4; k++) prog.push_back(encS(offs[k], 5'(2 + k), 5'd1));
        for (int k = 3; k >= 0; k--) begin
            prog.push_back(encI(offs[k], 5'd1, 3'b010, 5'(10 + k), opLoad));
            expReg[5'(10 + k)] = data[k];
        end
        loadProgram();
        runUntil(endProgram());
        checkRegs();
    endtask

    task automatic testBranch();
        logic [31:0] val [32];
        logic [2:0]  f3s [6];
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  mark;
        newProgram();
        val    = '{default: '0};
        val[1] = lfsrBits(32) | 32'h8000_0000;   // negative, large unsigned
        val[2] = lfsrBits(32) & 32'h7fff_ffff;   // positive, small unsigned
        val[3] = val[1];
        for (int r = 1; r < 4; r++) emitConst(5'(r), val[r]);
        f3s  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
        mark = 5'd10;
        for (int i = 0; i < 6; i++) begin
            for (int p = 0; p < 3; p++) begin    // pairs x1,x2  x2,x1  x1,x3
                rs1 = (p == 1) ? 5'd2 : 5'd1;
                rs2 = (p == 0) ? 5'd2 : ((p == 1) ? 5'd1 : 5'd3);
                prog.push_back(encB(13'd8, rs1, rs2, f3s[i]));          // jumps the marker
                prog.push_back(encI(12'd1, 5'd0, 3'd0, mark, opImm));   // fall through only
                expReg[mark] = branchRef(f3s[i], val[rs1], val[rs2]) ? 32'd0 : 32'd1;
                mark++;
            end
        end
        loadProgram();
        runUntil(endProgram());
        checkRegs();
    endtask

    task automatic testJump();
        logic [19:0] u;
        newProgram();
        u = 20'(lfsrBits(20));
        prog.push_back(encJ(21'd12, 5'd1));                     // 0  jal x1, +12
        prog.push_back(encI(12'd1, 5'd0, 3'd0, 5'd5, opImm));   // 4  skipped
        prog.push_back(encI(12'd2, 5'd0, 3'd0, 5'd5, opImm));   // 8  skipped
        prog.push_back(encU(u, 5'd2, opAuipc));                 // 12
        prog.push_back(encI(12'd29, 5'd0, 3'd0, 5'd3, opImm));  // 16
        prog.push_back(encI(12'd4, 5'd3, 3'd0, 5'd4, opJalr));  // 20 sum 33 lands on 32
        prog.push_back(encI(12'd1, 5'd0, 3'd0, 5'd6, opImm));   // 24 skipped
        prog.push_back(encI(12'd2, 5'd0, 3'd0, 5'd6, opImm));   // 28 skipped
        prog.push_back(encI(12'd9, 5'd0, 3'd0, 5'd7, opImm));   // 32
        expReg[1] = 32'd4;
        expReg[2] = 32'd12 + {u, 12'd0};
        expReg[3] = 32'd29;
        expReg[4] = 32'd24;
        expReg[7] = 32'd9;
        loadProgram();
        runUntil(endProgram());
        checkRegs();
    endtask

    task automatic testTiming();
        int n;
        n = 6;                             // cycles with run high
        newProgram();
        for (int k = 1; k <= 10; k++) begin
            prog.push_back(encI(12'(100 + k), 5'd0, 3'd0, 5'(k), opImm));
            if (k <= n) expReg[5'(k)] = 32'(100 + k);
        end
        void'(endProgram());
        loadProgram();
        run = 1'b1;
        repeat (n) @(posedge clk);
        #1 run = 1'b0;
        checkValue("pc", pc, 32'(4 * n));
        checkRegs();
    endtask

    initial begin
        rstN       = 1'b0;
        run        = 1'b0;
        imemWe     = 1'b0;
        imemAddr   = '0;
        imemData   = '0;
        dbgRegAddr = '0;
        testReset();
        testAlu();
        testMemory();
        testBranch();
        testJump();
        testTiming();
        $display("*** PASSED ***");
        $finish;
    end

endmodule
